// File: settings_pkg.sv
package settings_pkg;

	// Setting widths
	localparam int I2C_SPEED_W = 8;
	localparam int I2C_ADDR_W  = 16;
	localparam int GPIO_W      = 24;

	// Values after reset
	localparam logic [I2C_SPEED_W-1:0] I2C_SPEED_RST = 8'd99;
	localparam logic [I2C_ADDR_W-1:0]  I2C_ADDR_RST  = 16'hFFFF;
	localparam logic [GPIO_W-1:0]      GPIO_RST      = 24'h000000;

	typedef enum logic [2:0] {
		SET_I2C_SPEED, SET_I2C_ADDR, SET_GPIO_LEVEL, SET_GPIO_DIR, SET_GPIO_READ, SET_INVALID
	} setting_e;

	// Number of bytes a setting occupies on the bus
	function automatic logic [1:0] setting_bytes(setting_e s);
		case (s)
			SET_I2C_SPEED: return 2'd1;
			SET_I2C_ADDR:  return 2'd2;
			default:       return 2'd3;
		endcase
	endfunction

endpackage

// File: protocol_pkg.sv
package protocol_pkg;

	// Command codes as seen in the first byte of a frame
	typedef enum logic [7:0] {
		CMD_NONE       = 8'h00,
		CMD_VERSION    = 8'h76,
		CMD_QUERY_I2C  = 8'h49,
		CMD_SET_I2C    = 8'h69,
		CMD_QUERY_GPIO = 8'h47,
		CMD_SET_GPIO   = 8'h67
	} cmd_e;

	// Select bytes following a query or set command
	localparam logic [7:0] SEL_I2C_SPEED  = 8'h63;
	localparam logic [7:0] SEL_I2C_ADDR   = 8'h61;
	localparam logic [7:0] SEL_GPIO_LEVEL = 8'h6C;
	localparam logic [7:0] SEL_GPIO_DIR   = 8'h64;

	// Response codes
	localparam logic [7:0] ACK_CODE = 8'h41;
	localparam logic [7:0] NAK_CODE = 8'h4E;

	typedef enum logic [3:0] {
		ES_IDLE, ES_NAK,
		ES_VER_GATHER, ES_VER_CHECK,
		ES_QUERY_SEL, ES_QUERY_ACK,
		ES_SET_SEL, ES_SET_DATA, ES_SET_ACK, ES_SET_WAIT,
		ES_DATA_WAIT
	} engine_state_e;

endpackage

// File: cmd_if.sv
`timescale 1ns/1ps

interface cmd_if;

	protocol_pkg::cmd_e cmd;
	logic [7:0] eid;
	logic start;
	// Payload strobe with one byte per pulse
	logic [7:0] byte_data;
	logic byte_valid;
	logic nak_now;

	modport receiver (
		output cmd, eid, start, byte_data, byte_valid, nak_now
	);

	modport engine (
		input cmd, eid, start, byte_data, byte_valid, nak_now
	);

endinterface

// File: resp_if.sv
`timescale 1ns/1ps

interface resp_if;

	logic send_ack;
	logic send_nak;
	logic [7:0] eid;
	// Data frame request with a right aligned word
	logic data_req;
	logic [23:0] data_word;
	logic [1:0] data_len;
	logic busy;

	modport engine (
		output send_ack, send_nak, eid, data_req, data_word, data_len,
		input busy
	);

	modport framer (
		input send_ack, send_nak, eid, data_req, data_word, data_len,
		output busy
	);

endinterface

// File: cmd_receiver.sv
`timescale 1ns/1ps

module cmd_receiver (
	input logic clk,
	input logic rst,
	input logic [7:0] in_data,
	input logic in_valid,
	input logic in_frame,
	input logic nak_request,
	cmd_if.receiver cmd
);

	typedef enum logic [1:0] {PH_IDLE, PH_EID, PH_LEN, PH_PAY} phase_e;

	phase_e phase;
	logic frame_d;
	logic frame_start;
	protocol_pkg::cmd_e decoded;

	assign frame_start = in_frame && !frame_d;

	always_comb begin
		case (in_data)
			protocol_pkg::CMD_VERSION:    decoded = protocol_pkg::CMD_VERSION;
			protocol_pkg::CMD_QUERY_I2C:  decoded = protocol_pkg::CMD_QUERY_I2C;
			protocol_pkg::CMD_SET_I2C:    decoded = protocol_pkg::CMD_SET_I2C;
			protocol_pkg::CMD_QUERY_GPIO: decoded = protocol_pkg::CMD_QUERY_GPIO;
			protocol_pkg::CMD_SET_GPIO:   decoded = protocol_pkg::CMD_SET_GPIO;
			default:                      decoded = protocol_pkg::CMD_NONE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			frame_d <= 1'b0;
			phase <= PH_IDLE;
			cmd.cmd <= protocol_pkg::CMD_NONE;
			cmd.nak_now <= 1'b0;
			cmd.start <= 1'b0;
			cmd.byte_valid <= 1'b0;
		end else begin
			frame_d <= in_frame;
			cmd.start <= 1'b0;
			// Payload is registered so it never lands on the start cycle
			cmd.byte_valid <= (phase == PH_PAY) && in_valid && in_frame;
			if (frame_start) begin
				cmd.cmd <= decoded;
				cmd.nak_now <= nak_request;
				// Unknown code without a NAK request is dropped silently
				if (decoded != protocol_pkg::CMD_NONE || nak_request)
					phase <= PH_EID;
				else
					phase <= PH_IDLE;
			end else begin
				case (phase)
					PH_EID: if (in_valid) phase <= PH_LEN;
					PH_LEN: begin
						if (in_valid) begin
							cmd.start <= 1'b1;
							phase <= PH_PAY;
						end
					end
					PH_PAY: if (!in_frame) phase <= PH_IDLE;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (phase == PH_EID && in_valid && !frame_start)
			cmd.eid <= in_data;
		cmd.byte_data <= in_data;
	end

endmodule

// File: cmd_engine.sv
`timescale 1ns/1ps

module cmd_engine #(
	parameter logic [7:0] VERSION_MAJOR = 8'h00,
	parameter logic [7:0] VERSION_MINOR = 8'h02
) (
	input logic clk,
	input logic rst,
	input logic [settings_pkg::GPIO_W-1:0] read_value,
	cmd_if.engine cmd,
	resp_if.engine resp,
	output settings_pkg::setting_e sel_setting,
	output logic set_strobe,
	output logic [7:0] set_byte,
	output settings_pkg::setting_e set_target,
	output logic commit
);

	protocol_pkg::engine_state_e state, next_state;
	logic [1:0] byte_cnt;
	logic [15:0] ver_sr;
	settings_pkg::setting_e mapped;

	// Which setting a select byte names depends on the command
	function automatic settings_pkg::setting_e map_select(protocol_pkg::cmd_e c, logic [7:0] sel);
		settings_pkg::setting_e s;
		s = settings_pkg::SET_INVALID;
		if (c == protocol_pkg::CMD_QUERY_I2C || c == protocol_pkg::CMD_SET_I2C) begin
			if (sel == protocol_pkg::SEL_I2C_SPEED)
				s = settings_pkg::SET_I2C_SPEED;
			else if (sel == protocol_pkg::SEL_I2C_ADDR)
				s = settings_pkg::SET_I2C_ADDR;
		end else if (c == protocol_pkg::CMD_QUERY_GPIO) begin
			if (sel == protocol_pkg::SEL_GPIO_LEVEL)
				s = settings_pkg::SET_GPIO_READ;
			else if (sel == protocol_pkg::SEL_GPIO_DIR)
				s = settings_pkg::SET_GPIO_DIR;
		end else if (c == protocol_pkg::CMD_SET_GPIO) begin
			if (sel == protocol_pkg::SEL_GPIO_LEVEL)
				s = settings_pkg::SET_GPIO_LEVEL;
			else if (sel == protocol_pkg::SEL_GPIO_DIR)
				s = settings_pkg::SET_GPIO_DIR;
		end
		return s;
	endfunction

	assign mapped = map_select(cmd.cmd, cmd.byte_data);
	assign resp.eid = cmd.eid;
	assign set_byte = cmd.byte_data;
	assign set_strobe = (state == protocol_pkg::ES_SET_DATA) && cmd.byte_valid;

	always_comb begin
		next_state = state;
		resp.send_ack = 1'b0;
		resp.send_nak = 1'b0;
		resp.data_req = 1'b0;
		commit = 1'b0;
		case (state)
			protocol_pkg::ES_IDLE: begin
				if (cmd.start) begin
					if (cmd.nak_now)
						next_state = protocol_pkg::ES_NAK;
					else if (cmd.cmd == protocol_pkg::CMD_VERSION)
						next_state = protocol_pkg::ES_VER_GATHER;
					else if (cmd.cmd == protocol_pkg::CMD_QUERY_I2C ||
						cmd.cmd == protocol_pkg::CMD_QUERY_GPIO)
						next_state = protocol_pkg::ES_QUERY_SEL;
					else
						next_state = protocol_pkg::ES_SET_SEL;
				end
			end
			protocol_pkg::ES_NAK: begin
				if (!resp.busy) begin
					resp.send_nak = 1'b1;
					next_state = protocol_pkg::ES_IDLE;
				end
			end
			protocol_pkg::ES_VER_GATHER: begin
				if (cmd.byte_valid && byte_cnt == 2'd1)
					next_state = protocol_pkg::ES_VER_CHECK;
			end
			protocol_pkg::ES_VER_CHECK: begin
				if (!resp.busy) begin
					if (ver_sr == {VERSION_MAJOR, VERSION_MINOR}) begin
						resp.send_ack = 1'b1;
						next_state = protocol_pkg::ES_IDLE;
					end else begin
						resp.send_nak = 1'b1;
						next_state = protocol_pkg::ES_DATA_WAIT;
					end
				end
			end
			protocol_pkg::ES_QUERY_SEL: begin
				if (cmd.byte_valid) begin
					if (mapped == settings_pkg::SET_INVALID)
						next_state = protocol_pkg::ES_NAK;
					else
						next_state = protocol_pkg::ES_QUERY_ACK;
				end
			end
			protocol_pkg::ES_QUERY_ACK: begin
				if (!resp.busy) begin
					resp.send_ack = 1'b1;
					next_state = protocol_pkg::ES_DATA_WAIT;
				end
			end
			protocol_pkg::ES_SET_SEL: begin
				if (cmd.byte_valid) begin
					if (mapped == settings_pkg::SET_INVALID)
						next_state = protocol_pkg::ES_NAK;
					else
						next_state = protocol_pkg::ES_SET_DATA;
				end
			end
			protocol_pkg::ES_SET_DATA: begin
				if (cmd.byte_valid && byte_cnt == 2'd1)
					next_state = protocol_pkg::ES_SET_ACK;
			end
			protocol_pkg::ES_SET_ACK: begin
				if (!resp.busy) begin
					resp.send_ack = 1'b1;
					next_state = protocol_pkg::ES_SET_WAIT;
				end
			end
			// Busy is already high here, so low means the ACK has left
			protocol_pkg::ES_SET_WAIT: begin
				if (!resp.busy) begin
					commit = 1'b1;
					next_state = protocol_pkg::ES_IDLE;
				end
			end
			protocol_pkg::ES_DATA_WAIT: begin
				if (!resp.busy) begin
					resp.data_req = 1'b1;
					next_state = protocol_pkg::ES_IDLE;
				end
			end
			default: next_state = protocol_pkg::ES_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= protocol_pkg::ES_IDLE;
			byte_cnt <= 2'd0;
			sel_setting <= settings_pkg::SET_INVALID;
			set_target <= settings_pkg::SET_INVALID;
		end else begin
			state <= next_state;
			if (state == protocol_pkg::ES_IDLE && cmd.start)
				byte_cnt <= 2'd2;
			else if (state == protocol_pkg::ES_SET_SEL && cmd.byte_valid)
				byte_cnt <= settings_pkg::setting_bytes(mapped);
			else if (cmd.byte_valid && byte_cnt != 2'd0)
				byte_cnt <= byte_cnt - 2'd1;
			if (state == protocol_pkg::ES_QUERY_SEL && cmd.byte_valid)
				sel_setting <= mapped;
			if (state == protocol_pkg::ES_SET_SEL && cmd.byte_valid)
				set_target <= mapped;
		end
	end

	always_ff @(posedge clk) begin
		if (state == protocol_pkg::ES_VER_GATHER && cmd.byte_valid)
			ver_sr <= {ver_sr[7:0], cmd.byte_data};
		// Version reply on mismatch, or the queried value
		if (state == protocol_pkg::ES_VER_CHECK) begin
			resp.data_word <= {8'h00, VERSION_MAJOR, VERSION_MINOR};
			resp.data_len <= 2'd2;
		end else if (state == protocol_pkg::ES_QUERY_ACK) begin
			resp.data_word <= read_value;
			resp.data_len <= settings_pkg::setting_bytes(sel_setting);
		end
	end

endmodule

// File: setting_regs.sv
`timescale 1ns/1ps

module setting_regs (
	input logic clk,
	input logic rst,
	input settings_pkg::setting_e sel_setting,
	input logic set_strobe,
	input logic [7:0] set_byte,
	input settings_pkg::setting_e set_target,
	input logic commit,
	input logic [settings_pkg::GPIO_W-1:0] gpio_read,
	output logic [settings_pkg::GPIO_W-1:0] read_value,
	output logic [settings_pkg::I2C_SPEED_W-1:0] i2c_speed,
	output logic [settings_pkg::I2C_ADDR_W-1:0] i2c_addr,
	output logic [settings_pkg::GPIO_W-1:0] gpio_level,
	output logic [settings_pkg::GPIO_W-1:0] gpio_direction
);

	logic [settings_pkg::I2C_SPEED_W-1:0] speed_stage;
	logic [settings_pkg::I2C_ADDR_W-1:0] addr_stage;
	logic [settings_pkg::GPIO_W-1:0] level_stage;
	logic [settings_pkg::GPIO_W-1:0] dir_stage;

	// Bytes arrive MSB first
	always_ff @(posedge clk) begin
		if (set_strobe) begin
			case (set_target)
				settings_pkg::SET_I2C_SPEED: speed_stage <= set_byte;
				settings_pkg::SET_I2C_ADDR:
					addr_stage <= {addr_stage[settings_pkg::I2C_ADDR_W-9:0], set_byte};
				settings_pkg::SET_GPIO_LEVEL:
					level_stage <= {level_stage[settings_pkg::GPIO_W-9:0], set_byte};
				settings_pkg::SET_GPIO_DIR:
					dir_stage <= {dir_stage[settings_pkg::GPIO_W-9:0], set_byte};
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			i2c_speed <= settings_pkg::I2C_SPEED_RST;
			i2c_addr <= settings_pkg::I2C_ADDR_RST;
			gpio_level <= settings_pkg::GPIO_RST;
			gpio_direction <= settings_pkg::GPIO_RST;
		end else if (commit) begin
			case (set_target)
				settings_pkg::SET_I2C_SPEED:  i2c_speed <= speed_stage;
				settings_pkg::SET_I2C_ADDR:   i2c_addr <= addr_stage;
				settings_pkg::SET_GPIO_LEVEL: gpio_level <= level_stage;
				settings_pkg::SET_GPIO_DIR:   gpio_direction <= dir_stage;
				default: ;
			endcase
		end
	end

	// Read-back is right aligned
	always_comb begin
		case (sel_setting)
			settings_pkg::SET_I2C_SPEED:
				read_value = {{(settings_pkg::GPIO_W-settings_pkg::I2C_SPEED_W){1'b0}}, i2c_speed};
			settings_pkg::SET_I2C_ADDR:
				read_value = {{(settings_pkg::GPIO_W-settings_pkg::I2C_ADDR_W){1'b0}}, i2c_addr};
			settings_pkg::SET_GPIO_DIR:   read_value = gpio_direction;
			settings_pkg::SET_GPIO_READ:  read_value = gpio_read;
			default:                      read_value = '0;
		endcase
	end

endmodule

// File: resp_framer.sv
`timescale 1ns/1ps

module resp_framer (
	input logic clk,
	input logic rst,
	resp_if.framer resp,
	output logic [7:0] out_data,
	output logic out_valid,
	output logic out_frame
);

	logic active;
	logic [1:0] left;
	// Pending bytes with the next one to send on top
	logic [23:0] frame_sr;
	logic [23:0] data_aligned;

	// Move the right aligned word up so its MSB leads
	always_comb begin
		case (resp.data_len)
			2'd1:    data_aligned = {resp.data_word[7:0], 16'h0000};
			2'd2:    data_aligned = {resp.data_word[15:0], 8'h00};
			default: data_aligned = resp.data_word;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			left <= 2'd0;
		end else if (!active) begin
			if (resp.send_ack || resp.send_nak) begin
				active <= 1'b1;
				left <= 2'd2;
			end else if (resp.data_req) begin
				active <= 1'b1;
				left <= resp.data_len;
			end
		end else begin
			left <= left - 2'd1;
			if (left == 2'd1)
				active <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!active) begin
			if (resp.send_ack)
				frame_sr <= {protocol_pkg::ACK_CODE, resp.eid, 8'h00};
			else if (resp.send_nak)
				frame_sr <= {protocol_pkg::NAK_CODE, resp.eid, 8'h00};
			else if (resp.data_req)
				frame_sr <= data_aligned;
		end else begin
			frame_sr <= {frame_sr[15:0], 8'h00};
		end
	end

	assign out_data = frame_sr[23:16];
	assign out_valid = active;
	assign out_frame = active;
	assign resp.busy = active;

endmodule

// File: basics_top.sv
`timescale 1ns/1ps

module basics_top #(
	parameter logic [7:0] VERSION_MAJOR = 8'h00,
	parameter logic [7:0] VERSION_MINOR = 8'h02
) (
	input logic clk,
	input logic rst,
	input logic [7:0] in_data,
	input logic in_valid,
	input logic in_frame,
	input logic nak_request,
	input logic [settings_pkg::GPIO_W-1:0] gpio_read,
	output logic [7:0] out_data,
	output logic out_valid,
	output logic out_frame,
	output logic [settings_pkg::I2C_SPEED_W-1:0] i2c_speed,
	output logic [settings_pkg::I2C_ADDR_W-1:0] i2c_addr,
	output logic [settings_pkg::GPIO_W-1:0] gpio_level,
	output logic [settings_pkg::GPIO_W-1:0] gpio_direction
);

	cmd_if cmd_bus ();
	resp_if resp_bus ();

	settings_pkg::setting_e sel_setting;
	settings_pkg::setting_e set_target;
	logic [settings_pkg::GPIO_W-1:0] read_value;
	logic set_strobe;
	logic [7:0] set_byte;
	logic commit;

	cmd_receiver rx0 (
		.clk(clk),
		.rst(rst),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_frame(in_frame),
		.nak_request(nak_request),
		.cmd(cmd_bus.receiver)
	);

	cmd_engine #(
		.VERSION_MAJOR(VERSION_MAJOR),
		.VERSION_MINOR(VERSION_MINOR)
	) eng0 (
		.clk(clk),
		.rst(rst),
		.read_value(read_value),
		.cmd(cmd_bus.engine),
		.resp(resp_bus.engine),
		.sel_setting(sel_setting),
		.set_strobe(set_strobe),
		.set_byte(set_byte),
		.set_target(set_target),
		.commit(commit)
	);

	setting_regs regs0 (
		.clk(clk),
		.rst(rst),
		.sel_setting(sel_setting),
		.set_strobe(set_strobe),
		.set_byte(set_byte),
		.set_target(set_target),
		.commit(commit),
		.gpio_read(gpio_read),
		.read_value(read_value),
		.i2c_speed(i2c_speed),
		.i2c_addr(i2c_addr),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction)
	);

	resp_framer fr0 (
		.clk(clk),
		.rst(rst),
		.resp(resp_bus.framer),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_frame(out_frame)
	);

endmodule

// File: tb_basics.sv
`timescale 1ns/1ps

module tb_basics;

	localparam int NUM_ENTRIES = 14;
	localparam int CYCLE_LIMIT = NUM_ENTRIES * 60;
	localparam logic [23:0] GPIO_READ_VAL = 24'h5AC30F;

	logic clk;
	logic rst;
	logic [7:0] in_data;
	logic in_valid;
	logic in_frame;
	logic nak_request;
	logic [23:0] gpio_read;
	logic [7:0] out_data;
	logic out_valid;
	logic out_frame;
	logic [7:0] i2c_speed;
	logic [15:0] i2c_addr;
	logic [23:0] gpio_level;
	logic [23:0] gpio_direction;

	// One row per command frame
	logic [7:0] in_bytes [NUM_ENTRIES][7];
	int in_count [NUM_ENTRIES];
	logic nak_req [NUM_ENTRIES];
	logic [7:0] exp_bytes [NUM_ENTRIES][7];
	int exp_count [NUM_ENTRIES];
	int exp_frames [NUM_ENTRIES];
	int exp_first_len [NUM_ENTRIES];
	logic [7:0] exp_speed [NUM_ENTRIES];
	logic [15:0] exp_addr [NUM_ENTRIES];
	logic [23:0] exp_level [NUM_ENTRIES];
	logic [23:0] exp_dir [NUM_ENTRIES];

	logic [7:0] seen_bytes [$];
	int frame_lens [$];
	int cur_len;
	logic frame_d;
	// Settings in force before the current entry
	logic [7:0] prev_speed;
	logic [15:0] prev_addr;
	logic [23:0] prev_level;
	logic [23:0] prev_dir;
	integer seed;
	int cycles;
	int value_errors;
	int frame_errors;

	basics_top #(
		.VERSION_MAJOR(8'h00),
		.VERSION_MINOR(8'h02)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_frame(in_frame),
		.nak_request(nak_request),
		.gpio_read(gpio_read),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_frame(out_frame),
		.i2c_speed(i2c_speed),
		.i2c_addr(i2c_addr),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction)
	);

	always #2 clk = ~clk;

	task automatic report_value(input string name, input logic [23:0] expected,
		input logic [23:0] actual);
		$display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
		value_errors++;
	endtask

	task automatic set_input(input int i, input logic [55:0] b, input int n, input logic nak);
		for (int k = 0; k < 7; k++)
			in_bytes[i][k] = b[55-8*k -: 8];
		in_count[i] = n;
		nak_req[i] = nak;
	endtask

	task automatic set_expect(input int i, input logic [55:0] b, input int n, input int frames,
		input int first_len);
		for (int k = 0; k < 7; k++)
			exp_bytes[i][k] = b[55-8*k -: 8];
		exp_count[i] = n;
		exp_frames[i] = frames;
		exp_first_len[i] = first_len;
	endtask

	task automatic set_settings(input int i, input logic [7:0] s, input logic [15:0] a,
		input logic [23:0] l, input logic [23:0] d);
		exp_speed[i] = s;
		exp_addr[i] = a;
		exp_level[i] = l;
		exp_dir[i] = d;
	endtask

	task automatic load_table();
		// Version match, then mismatch with the version data frame
		set_input(0, 56'h76_10_02_00_02_00_00, 5, 1'b0);
		set_expect(0, 56'h41_10_00_00_00_00_00, 2, 1, 2);
		set_settings(0, 8'd99, 16'hFFFF, 24'h0, 24'h0);
		set_input(1, 56'h76_11_02_01_00_00_00, 5, 1'b0);
		set_expect(1, 56'h4E_11_00_02_00_00_00, 4, 2, 2);
		set_settings(1, 8'd99, 16'hFFFF, 24'h0, 24'h0);
		// I2C speed and address, then read the address back
		set_input(2, 56'h69_12_02_63_2A_00_00, 5, 1'b0);
		set_expect(2, 56'h41_12_00_00_00_00_00, 2, 1, 2);
		set_settings(2, 8'h2A, 16'hFFFF, 24'h0, 24'h0);
		set_input(3, 56'h69_13_03_61_BE_EF_00, 6, 1'b0);
		set_expect(3, 56'h41_13_00_00_00_00_00, 2, 1, 2);
		set_settings(3, 8'h2A, 16'hBEEF, 24'h0, 24'h0);
		set_input(4, 56'h49_14_01_61_00_00_00, 4, 1'b0);
		set_expect(4, 56'h41_14_BE_EF_00_00_00, 4, 2, 2);
		set_settings(4, 8'h2A, 16'hBEEF, 24'h0, 24'h0);
		// GPIO direction, then read-back of the GPIO input pins
		set_input(5, 56'h67_15_04_64_12_34_56, 7, 1'b0);
		set_expect(5, 56'h41_15_00_00_00_00_00, 2, 1, 2);
		set_settings(5, 8'h2A, 16'hBEEF, 24'h0, 24'h123456);
		set_input(6, 56'h47_16_01_6C_00_00_00, 4, 1'b0);
		set_expect(6, {16'h41_16, GPIO_READ_VAL, 16'h0}, 5, 2, 2);
		set_settings(6, 8'h2A, 16'hBEEF, 24'h0, 24'h123456);
		// NAK request, unknown selects, unknown command
		set_input(7, 56'h76_17_02_00_00_00_00, 3, 1'b1);
		set_expect(7, 56'h4E_17_00_00_00_00_00, 2, 1, 2);
		set_settings(7, 8'h2A, 16'hBEEF, 24'h0, 24'h123456);
		set_input(8, 56'h49_18_01_7A_00_00_00, 4, 1'b0);
		set_expect(8, 56'h4E_18_00_00_00_00_00, 2, 1, 2);
		set_settings(8, 8'h2A, 16'hBEEF, 24'h0, 24'h123456);
		set_input(9, 56'h67_19_04_71_01_02_03, 7, 1'b0);
		set_expect(9, 56'h4E_19_00_00_00_00_00, 2, 1, 2);
		set_settings(9, 8'h2A, 16'hBEEF, 24'h0, 24'h123456);
		set_input(10, 56'h55_1A_01_00_00_00_00, 4, 1'b0);
		set_expect(10, 56'h0, 0, 0, 0);
		set_settings(10, 8'h2A, 16'hBEEF, 24'h0, 24'h123456);
		// GPIO level, then a one byte query of the speed
		set_input(11, 56'h67_1B_04_6C_0A_0B_0C, 7, 1'b0);
		set_expect(11, 56'h41_1B_00_00_00_00_00, 2, 1, 2);
		set_settings(11, 8'h2A, 16'hBEEF, 24'h0A0B0C, 24'h123456);
		set_input(12, 56'h49_1C_01_63_00_00_00, 4, 1'b0);
		set_expect(12, 56'h41_1C_2A_00_00_00_00, 3, 2, 2);
		set_settings(12, 8'h2A, 16'hBEEF, 24'h0A0B0C, 24'h123456);
		// Read-back of the GPIO direction setting
		set_input(13, 56'h47_1D_01_64_00_00_00, 4, 1'b0);
		set_expect(13, 56'h41_1D_12_34_56_00_00, 5, 2, 2);
		set_settings(13, 8'h2A, 16'hBEEF, 24'h0A0B0C, 24'h123456);
	endtask

	// Caller is 0.5 ns past a rising edge
	task automatic send_frame(input int idx);
		int gap;
		for (int k = 0; k < in_count[idx]; k++) begin
			if (k > 0) begin
				gap = $unsigned($random(seed)) % 3;
				in_valid = 1'b0;
				nak_request = 1'b0;
				repeat (gap) begin
					@(posedge clk);
					#0.5;
				end
			end
			in_frame = 1'b1;
			in_valid = 1'b1;
			in_data = in_bytes[idx][k];
			if (k == 0)
				nak_request = nak_req[idx];
			@(posedge clk);
			#0.5;
		end
		in_frame = 1'b0;
		in_valid = 1'b0;
		nak_request = 1'b0;
	endtask

	task automatic check_settings(input logic [7:0] s, input logic [15:0] a,
		input logic [23:0] l, input logic [23:0] d);
		if (i2c_speed !== s)
			report_value("i2c_speed", {16'h0, s}, {16'h0, i2c_speed});
		if (i2c_addr !== a)
			report_value("i2c_addr", {8'h0, a}, {8'h0, i2c_addr});
		if (gpio_level !== l)
			report_value("gpio_level", l, gpio_level);
		if (gpio_direction !== d)
			report_value("gpio_direction", d, gpio_direction);
	endtask

	task automatic check_response(input int i);
		if (frame_lens.size() != exp_frames[i]) begin
			$display("entry %0d: expected %0d response frames but saw %0d",
				i, exp_frames[i], frame_lens.size());
			frame_errors++;
		end else if (seen_bytes.size() != exp_count[i]) begin
			$display("entry %0d: expected %0d response bytes but saw %0d",
				i, exp_count[i], seen_bytes.size());
			frame_errors++;
		end else begin
			if (exp_frames[i] > 0 && frame_lens[0] != exp_first_len[i]) begin
				$display("entry %0d: first frame has %0d bytes instead of %0d",
					i, frame_lens[0], exp_first_len[i]);
				frame_errors++;
			end
			for (int k = 0; k < exp_count[i]; k++) begin
				if (seen_bytes[k] !== exp_bytes[i][k])
					report_value("out_data", {16'h0, exp_bytes[i][k]}, {16'h0, seen_bytes[k]});
			end
		end
	endtask

	// Output monitor sampled away from the rising edge
	always @(negedge clk) begin
		if (out_valid) begin
			seen_bytes.push_back(out_data);
			cur_len++;
		end
		if (frame_d && !out_frame) begin
			frame_lens.push_back(cur_len);
			cur_len = 0;
		end
		// No setting may move before its ACK frame has ended
		if (out_frame || frame_d)
			check_settings(prev_speed, prev_addr, prev_level, prev_dir);
		frame_d = out_frame;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the DUT did not finish its response", cycles);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		seed = 32'h063e_cd9d;
		clk = 1'b0;
		rst = 1'b1;
		in_data = 8'h00;
		in_valid = 1'b0;
		in_frame = 1'b0;
		nak_request = 1'b0;
		gpio_read = GPIO_READ_VAL;
		frame_d = 1'b0;
		cur_len = 0;
		cycles = 0;
		value_errors = 0;
		frame_errors = 0;
		prev_speed = 8'd99;
		prev_addr = 16'hFFFF;
		prev_level = 24'h0;
		prev_dir = 24'h0;
		load_table();
		repeat (5) @(posedge clk);
		#0.5;
		rst = 1'b0;
		check_settings(8'd99, 16'hFFFF, 24'h0, 24'h0);
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			seen_bytes.delete();
			frame_lens.delete();
			cur_len = 0;
			send_frame(i);
			while (frame_lens.size() < exp_frames[i]) begin
				@(posedge clk);
				#0.5;
			end
			// Quiet window catches stray frames and the late commit
			repeat (8) @(posedge clk);
			#0.5;
			check_response(i);
			check_settings(exp_speed[i], exp_addr[i], exp_level[i], exp_dir[i]);
			prev_speed = exp_speed[i];
			prev_addr = exp_addr[i];
			prev_level = exp_level[i];
			prev_dir = exp_dir[i];
		end
		$display("value errors: %0d, frame errors: %0d", value_errors, frame_errors);
		if (value_errors == 0 && frame_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
settings_pkg.sv
protocol_pkg.sv
cmd_if.sv
resp_if.sv
cmd_receiver.sv
cmd_engine.sv
setting_regs.sv
resp_framer.sv
basics_top.sv
tb_basics.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_basics
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
